// ==== Bender.yml ====
package:
  name: alu_pipe

sources:
  - design/aluPkg.sv
  - design/cmdFifo.sv
  - design/creditIssue.sv
  - design/aluDecode.sv
  - design/aluExecute.sv
  - design/aluTop.sv
  - target: simulation
    files:
      - sim/aluTb.sv

// ==== design/aluDecode.sv ====
`timescale 1ns/1ps
`default_nettype none

module aluDecode import aluPkg::*; (
    input  wire logic                 clk,
    input  wire logic                 rstN,
    input  wire logic                 inValid,
    input  instrWord                  instr,
    input  wire logic [DataWidth-1:0] regA,
    input  wire logic [DataWidth-1:0] regB,
    output logic                      decValid,
    output logic      [OpWidth-1:0]   opCode,
    output logic      [DataWidth-1:0] opA,
    output logic      [DataWidth-1:0] opB,
    output logic      [4:0]           shiftAmt,
    output logic      [DataWidth-1:0] branchTarget,
    output logic                      illegal
);

    logic                 isR;
    logic [4:0]           rsField;
    logic [4:0]           rtField;
    logic [DataWidth-1:0] rsVal;
    logic [DataWidth-1:0] rtVal;
    logic [DataWidth-1:0] immSext;
    logic [DataWidth-1:0] immZext;
    logic                 usesRt;
    logic                 badReg;
    logic                 badCode;
    logic [OpWidth-1:0]   opNext;
    logic [DataWidth-1:0] opANext;
    logic [DataWidth-1:0] opBNext;
    logic [4:0]           shNext;

    assign isR     = (instr.rType.opcode == OpcRType);
    assign rsField = instr.rType.rs;
    assign rtField = instr.rType.rt;
    assign rsVal   = rsField[0] ? regB : regA;          // Field 0 is regA, 1 is regB
    assign rtVal   = rtField[0] ? regB : regA;
    assign immSext = {{(DataWidth-16){instr.iType.imm[15]}}, instr.iType.imm};
    assign immZext = {{(DataWidth-16){1'b0}}, instr.iType.imm};
    assign usesRt  = isR || (instr.iType.opcode == OpcBeq) || (instr.iType.opcode == OpcBne);
    assign badReg  = (rsField > 5'd1) || (usesRt && (rtField > 5'd1));

    always_comb begin
        opNext  = AluNop;
        opANext = rsVal;
        opBNext = rtVal;
        shNext  = '0;
        badCode = 1'b0;
        if (isR) begin
            case (instr.rType.func)
                FnAdd:  opNext = AluAddOvf;
                FnAddu: opNext = AluAdd;
                FnSub:  opNext = AluSubOvf;
                FnSubu: opNext = AluSub;
                FnAnd:  opNext = AluAnd;
                FnOr:   opNext = AluOr;
                FnXor:  opNext = AluXor;
                FnNor:  opNext = AluNor;
                FnSlt:  opNext = AluSlt;
                FnSltu: opNext = AluSltu;
                FnSll, FnSrl, FnSra: begin
                    opANext = rtVal;                   // Value being shifted
                    shNext  = instr.rType.shamt;
                    opNext  = (instr.rType.func == FnSll) ? AluSll :
                              (instr.rType.func == FnSrl) ? AluSrl : AluSra;
                end
                FnSllv, FnSrlv, FnSrav: begin
                    opANext = rtVal;
                    shNext  = rsVal[4:0];
                    opNext  = (instr.rType.func == FnSllv) ? AluSll :
                              (instr.rType.func == FnSrlv) ? AluSrl : AluSra;
                end
                default: badCode = 1'b1;
            endcase
        end else begin
            opBNext = immSext;
            case (instr.iType.opcode)
                OpcAddi:  opNext = AluAddOvf;
                OpcAddiu: opNext = AluAdd;
                OpcSlti:  opNext = AluSlt;
                OpcSltiu: opNext = AluSltu;          // Sign-extended, unsigned compare
                OpcOri: begin
                    opNext  = AluOr;
                    opBNext = immZext;
                end
                OpcXori: begin
                    opNext  = AluXor;
                    opBNext = immZext;
                end
                OpcBeq, OpcBne: begin
                    opNext  = (instr.iType.opcode == OpcBeq) ? AluBeq : AluBne;
                    opBNext = rtVal;
                end
                default: badCode = 1'b1;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            decValid <= 1'b0;
        end else begin
            decValid <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (inValid) begin
            opCode       <= (badReg || badCode) ? AluNop : opNext;
            opA          <= opANext;
            opB          <= opBNext;
            shiftAmt     <= shNext;
            branchTarget <= immSext << 2;
            illegal      <= badReg || badCode;
        end
    end

endmodule

`default_nettype wire

// ==== design/aluExecute.sv ====
`timescale 1ns/1ps
`default_nettype none

module aluExecute import aluPkg::*; (
    input  wire logic                 clk,
    input  wire logic                 rstN,
    input  wire logic                 decValid,
    input  wire logic [OpWidth-1:0]   opCode,
    input  wire logic [DataWidth-1:0] opA,
    input  wire logic [DataWidth-1:0] opB,
    input  wire logic [4:0]           shiftAmt,
    input  wire logic [DataWidth-1:0] branchTarget,
    input  wire logic                 illegal,
    output logic                      outValid,
    output logic      [DataWidth-1:0] result,
    output logic      [2:0]           flags,
    output logic                      illegalOut
);

    localparam int Msb = DataWidth - 1;

    logic [DataWidth-1:0] sum;
    logic [DataWidth-1:0] diff;
    logic                 same;
    logic [DataWidth-1:0] resNext;
    logic [2:0]           flagsNext;

    assign sum  = opA + opB;
    assign diff = opA - opB;
    assign same = (opA == opB);

    always_comb begin
        resNext   = '0;
        flagsNext = '0;
        case (opCode)
            AluAdd: resNext = sum;
            AluAddOvf: begin
                resNext            = sum;
                flagsNext[FlagOvf] = (opA[Msb] == opB[Msb]) && (sum[Msb] != opA[Msb]);
            end
            AluSub: resNext = diff;
            AluSubOvf: begin
                resNext            = diff;
                flagsNext[FlagOvf] = (opA[Msb] != opB[Msb]) && (diff[Msb] != opA[Msb]);
            end
            AluAnd: resNext = opA & opB;
            AluOr:  resNext = opA | opB;
            AluXor: resNext = opA ^ opB;
            AluNor: resNext = ~(opA | opB);
            AluSlt: begin
                resNext            = diff;
                flagsNext[FlagNeg] = ($signed(opA) < $signed(opB));
            end
            AluSltu: begin
                resNext            = diff;
                flagsNext[FlagNeg] = (opA < opB);
            end
            AluSll: resNext = opA << shiftAmt;
            AluSrl: resNext = opA >> shiftAmt;
            AluSra: resNext = $signed(opA) >>> shiftAmt;
            AluBeq: begin
                flagsNext[FlagZero] = same;
                resNext             = same ? branchTarget : DataWidth'(4);
            end
            AluBne: begin
                flagsNext[FlagZero] = same;
                resNext             = same ? DataWidth'(4) : branchTarget;
            end
            default: begin                         // AluNop
                resNext   = '0;
                flagsNext = '0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            outValid <= 1'b0;
        end else begin
            outValid <= decValid;
        end
    end

    always_ff @(posedge clk) begin
        if (decValid) begin
            result     <= resNext;
            flags      <= flagsNext;
            illegalOut <= illegal;
        end
    end

endmodule

`default_nettype wire

// ==== design/aluPkg.sv ====
`default_nettype none

package aluPkg;

    localparam int DataWidth = 32;
    localparam int OpWidth   = 5;

    // One instruction word, two ways to read it
    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] func;
        } rType;
        struct packed {
            logic [5:0]  opcode;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm;
        } iType;
    } instrWord;

    // Opcodes
    localparam logic [5:0] OpcRType = 6'b000000;
    localparam logic [5:0] OpcAddi  = 6'b001000;
    localparam logic [5:0] OpcAddiu = 6'b001001;
    localparam logic [5:0] OpcSlti  = 6'b001010;
    localparam logic [5:0] OpcSltiu = 6'b001011;
    localparam logic [5:0] OpcOri   = 6'b001101;
    localparam logic [5:0] OpcXori  = 6'b001110;
    localparam logic [5:0] OpcBeq   = 6'b000100;
    localparam logic [5:0] OpcBne   = 6'b000101;

    // R-type function codes
    localparam logic [5:0] FnSll  = 6'b000000;
    localparam logic [5:0] FnSrl  = 6'b000010;
    localparam logic [5:0] FnSra  = 6'b000011;
    localparam logic [5:0] FnSllv = 6'b000100;
    localparam logic [5:0] FnSrlv = 6'b000110;
    localparam logic [5:0] FnSrav = 6'b000111;
    localparam logic [5:0] FnAdd  = 6'b100000;
    localparam logic [5:0] FnAddu = 6'b100001;
    localparam logic [5:0] FnSub  = 6'b100010;
    localparam logic [5:0] FnSubu = 6'b100011;
    localparam logic [5:0] FnAnd  = 6'b100100;
    localparam logic [5:0] FnOr   = 6'b100101;
    localparam logic [5:0] FnXor  = 6'b100110;
    localparam logic [5:0] FnNor  = 6'b100111;
    localparam logic [5:0] FnSlt  = 6'b101010;
    localparam logic [5:0] FnSltu = 6'b101011;

    // Decoded operations, decode to execute
    localparam logic [OpWidth-1:0] AluAdd    = 5'd0;
    localparam logic [OpWidth-1:0] AluAddOvf = 5'd1;
    localparam logic [OpWidth-1:0] AluSub    = 5'd2;
    localparam logic [OpWidth-1:0] AluSubOvf = 5'd3;
    localparam logic [OpWidth-1:0] AluAnd    = 5'd4;
    localparam logic [OpWidth-1:0] AluOr     = 5'd5;
    localparam logic [OpWidth-1:0] AluXor    = 5'd6;
    localparam logic [OpWidth-1:0] AluNor    = 5'd7;
    localparam logic [OpWidth-1:0] AluSlt    = 5'd8;
    localparam logic [OpWidth-1:0] AluSltu   = 5'd9;
    localparam logic [OpWidth-1:0] AluSll    = 5'd10;
    localparam logic [OpWidth-1:0] AluSrl    = 5'd11;
    localparam logic [OpWidth-1:0] AluSra    = 5'd12;
    localparam logic [OpWidth-1:0] AluBeq    = 5'd13;
    localparam logic [OpWidth-1:0] AluBne    = 5'd14;
    localparam logic [OpWidth-1:0] AluNop    = 5'd15;

    // Bit positions in flags
    localparam int FlagZero = 2;
    localparam int FlagNeg  = 1;
    localparam int FlagOvf  = 0;

endpackage

`default_nettype wire

// ==== design/aluTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module aluTop import aluPkg::*; #(
    parameter int FifoDepth  = 4,
    parameter int OutCredits = 2
) (
    input  wire logic                 clk,
    input  wire logic                 rstN,
    input  wire logic                 inValid,
    input  instrWord                  instr,
    input  wire logic [DataWidth-1:0] regA,
    input  wire logic [DataWidth-1:0] regB,
    output logic                      inCredit,
    output logic                      outValid,
    output logic      [DataWidth-1:0] result,
    output logic      [2:0]           flags,
    output logic                      illegal,
    input  wire logic                 outCredit
);

    instrWord             headInstr;
    logic [DataWidth-1:0] headA;
    logic [DataWidth-1:0] headB;
    logic                 notEmpty;
    logic                 pop;
    logic                 decValid;
    logic [OpWidth-1:0]   opCode;
    logic [DataWidth-1:0] opA;
    logic [DataWidth-1:0] opB;
    logic [4:0]           shiftAmt;
    logic [DataWidth-1:0] branchTarget;
    logic                 decIllegal;

    cmdFifo #(.FifoDepth(FifoDepth)) uFifo (
        .clk, .rstN,
        .push(inValid), .pushInstr(instr), .pushA(regA), .pushB(regB),
        .pop, .headInstr, .headA, .headB, .notEmpty, .inCredit
    );

    creditIssue #(.OutCredits(OutCredits)) uIssue (
        .clk, .rstN, .notEmpty, .outCredit, .pop
    );

    aluDecode uDecode (
        .clk, .rstN,
        .inValid(pop), .instr(headInstr), .regA(headA), .regB(headB),
        .decValid, .opCode, .opA, .opB, .shiftAmt, .branchTarget,
        .illegal(decIllegal)
    );

    aluExecute uExecute (
        .clk, .rstN,
        .decValid, .opCode, .opA, .opB, .shiftAmt, .branchTarget,
        .illegal(decIllegal),
        .outValid, .result, .flags, .illegalOut(illegal)
    );

endmodule

`default_nettype wire

// ==== design/cmdFifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module cmdFifo import aluPkg::*; #(
    parameter int FifoDepth = 4
) (
    input  wire logic                 clk,
    input  wire logic                 rstN,
    input  wire logic                 push,
    input  instrWord                  pushInstr,
    input  wire logic [DataWidth-1:0] pushA,
    input  wire logic [DataWidth-1:0] pushB,
    input  wire logic                 pop,
    output instrWord                  headInstr,
    output logic      [DataWidth-1:0] headA,
    output logic      [DataWidth-1:0] headB,
    output logic                      notEmpty,
    output logic                      inCredit
);

    localparam int PtrW = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
    localparam int CntW = $clog2(FifoDepth + 1);

    instrWord             memInstr [FifoDepth];
    logic [DataWidth-1:0] memA     [FifoDepth];
    logic [DataWidth-1:0] memB     [FifoDepth];
    logic [PtrW-1:0]      wrPtr;
    logic [PtrW-1:0]      rdPtr;
    logic [CntW-1:0]      count;
    logic                 full;
    logic                 doPush;
    logic                 doPop;

    assign full      = (count == CntW'(FifoDepth));
    assign notEmpty  = (count != '0);
    assign doPush    = push && !full;
    assign doPop     = pop && notEmpty;
    assign headInstr = memInstr[rdPtr];
    assign headA     = memA[rdPtr];
    assign headB     = memB[rdPtr];

    always_ff @(posedge clk) begin
        if (doPush) begin
            memInstr[wrPtr] <= pushInstr;
            memA[wrPtr]     <= pushA;
            memB[wrPtr]     <= pushB;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wrPtr    <= '0;
            rdPtr    <= '0;
            count    <= '0;
            inCredit <= 1'b0;
        end else begin
            inCredit <= doPop;                       // One credit per freed slot
            if (doPush) begin
                wrPtr <= (wrPtr == PtrW'(FifoDepth - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= (rdPtr == PtrW'(FifoDepth - 1)) ? '0 : rdPtr + 1'b1;
            end
            if (doPush && !doPop) begin
                count <= count + 1'b1;
            end else if (doPop && !doPush) begin
                count <= count - 1'b1;
            end
        end
    end

    // Sender must respect its input credits
    noPushFull: assert property (@(posedge clk) disable iff (!rstN) push |-> !full)
        else $error("cmdFifo push while full");
    noPopEmpty: assert property (@(posedge clk) disable iff (!rstN) pop |-> notEmpty)
        else $error("cmdFifo pop while empty");

endmodule

`default_nettype wire

// ==== design/creditIssue.sv ====
`timescale 1ns/1ps
`default_nettype none

module creditIssue #(
    parameter int OutCredits = 2
) (
    input  wire logic clk,
    input  wire logic rstN,
    input  wire logic notEmpty,
    input  wire logic outCredit,
    output logic      pop
);

    localparam int CntW = $clog2(OutCredits + 1);

    logic [CntW-1:0] count;

    assign pop = notEmpty && (count != '0);          // Issue only with a reserved slot

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            count <= CntW'(OutCredits);
        end else begin
            case ({pop, outCredit})
                2'b10:   count <= count - 1'b1;
                2'b01:   count <= count + 1'b1;
                default: count <= count;              // Both or neither
            endcase
        end
    end

    countBound: assert property (@(posedge clk) disable iff (!rstN)
        count <= CntW'(OutCredits))
        else $error("creditIssue count above OutCredits");

    // A returned credit needs a result outstanding
    noSpareCredit: assert property (@(posedge clk) disable iff (!rstN)
        outCredit |-> (count != CntW'(OutCredits)))
        else $error("creditIssue credit returned with none outstanding");

endmodule

`default_nettype wire

// ==== sim.f ====
design/aluPkg.sv
design/cmdFifo.sv
design/creditIssue.sv
design/aluDecode.sv
design/aluExecute.sv
design/aluTop.sv
sim/aluTb.sv

// ==== sim/aluTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module aluTb import aluPkg::*; ;

    localparam int FifoDepth   = 4;
    localparam int OutCredits  = 2;
    localparam int ClkPeriod   = 20;
    localparam int ResetCycles = 5;
    localparam int CmdBudget   = 100;                // Upper bound on commands sent

    logic                 clk;
    logic                 rstN;
    logic                 inValid;
    instrWord             instr;
    logic [DataWidth-1:0] regA;
    logic [DataWidth-1:0] regB;
    logic                 inCredit;
    logic                 outValid;
    logic [DataWidth-1:0] result;
    logic [2:0]           flags;
    logic                 illegal;
    logic                 outCredit;

    logic [DataWidth-1:0] expResult  [$];
    logic [2:0]           expFlags   [$];
    logic                 expIllegal [$];

    logic [31:0] lcgState = 32'h1ef7_f28e;
    int sendCredits    = FifoDepth;                  // Sender side input credits
    int owedCredits    = 0;                          // Results taken, credit not yet returned
    int outCount       = 0;
    int inCreditCount  = 0;
    int valueErrors    = 0;
    int otherErrors    = 0;
    logic consumerPaused = 1'b0;

    aluTop #(.FifoDepth(FifoDepth), .OutCredits(OutCredits)) UUT (
        .clk, .rstN, .inValid, .instr, .regA, .regB,
        .inCredit, .outValid, .result, .flags, .illegal, .outCredit
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic instrWord rInstr(input logic [5:0] func, input logic [4:0] rs,
                                        input logic [4:0] rt, input logic [4:0] shamt);
        instrWord w;
        w.rType.opcode = OpcRType;
        w.rType.rs     = rs;
        w.rType.rt     = rt;
        w.rType.rd     = 5'd0;
        w.rType.shamt  = shamt;
        w.rType.func   = func;
        return w;
    endfunction

    function automatic instrWord iInstr(input logic [5:0] opc, input logic [4:0] rs,
                                        input logic [4:0] rt, input logic [15:0] imm);
        instrWord w;
        w.iType.opcode = opc;
        w.iType.rs     = rs;
        w.iType.rt     = rt;
        w.iType.imm    = imm;
        return w;
    endfunction

    task automatic checkResult(input logic [DataWidth-1:0] expected,
                               input logic [DataWidth-1:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] result expected %h got %h (output %0d)", expected, actual, outCount);
            valueErrors++;
        end
    endtask

    task automatic checkFlags(input logic [2:0] expected, input logic [2:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] flags expected %h got %h (output %0d)", expected, actual, outCount);
            valueErrors++;
        end
    endtask

    task automatic checkIllegal(input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("[ERROR] illegal expected %h got %h (output %0d)", expected, actual, outCount);
            valueErrors++;
        end
    endtask

    task automatic checkLow(input string name, input logic actual);
        if (actual !== 1'b0) begin
            $display("[ERROR] %s during reset expected %h got %h", name, 1'b0, actual);
            valueErrors++;
        end
    endtask

    // Expected outputs straight from the instruction set rules
    task automatic predict(input instrWord ins, input logic [DataWidth-1:0] a,
                           input logic [DataWidth-1:0] b);
        logic [5:0]           opc;
        logic [4:0]           rs;
        logic [4:0]           rt;
        logic [DataWidth-1:0] x;
        logic [DataWidth-1:0] y;
        logic [DataWidth-1:0] sImm;
        logic [DataWidth-1:0] zImm;
        logic [DataWidth-1:0] res;
        logic [2:0]           fl;
        logic                 bad;
        longint               wide;
        opc  = ins.iType.opcode;
        rs   = ins.iType.rs;
        rt   = ins.iType.rt;
        x    = (rs == 5'd1) ? b : a;
        y    = (rt == 5'd1) ? b : a;
        sImm = DataWidth'($signed(ins.iType.imm));
        zImm = DataWidth'(ins.iType.imm);
        res  = '0;
        fl   = '0;
        bad  = (rs > 5'd1);
        if (opc == OpcRType || opc == OpcBeq || opc == OpcBne) begin
            bad = bad || (rt > 5'd1);
        end
        if (opc == OpcRType) begin
            case (ins.rType.func)
                FnAdd, FnAddu: begin
                    res  = x + y;
                    wide = longint'($signed(x)) + longint'($signed(y));
                    fl[FlagOvf] = (ins.rType.func == FnAdd) && (wide != longint'($signed(res)));
                end
                FnSub, FnSubu: begin
                    res  = x - y;
                    wide = longint'($signed(x)) - longint'($signed(y));
                    fl[FlagOvf] = (ins.rType.func == FnSub) && (wide != longint'($signed(res)));
                end
                FnAnd:  res = x & y;
                FnOr:   res = x | y;
                FnXor:  res = x ^ y;
                FnNor:  res = ~(x | y);
                FnSlt: begin
                    res         = x - y;
                    fl[FlagNeg] = $signed(x) < $signed(y);
                end
                FnSltu: begin
                    res         = x - y;
                    fl[FlagNeg] = x < y;
                end
                FnSll:  res = y << ins.rType.shamt;
                FnSrl:  res = y >> ins.rType.shamt;
                FnSra:  res = $signed(y) >>> ins.rType.shamt;
                FnSllv: res = y << x[4:0];
                FnSrlv: res = y >> x[4:0];
                FnSrav: res = $signed(y) >>> x[4:0];
                default: bad = 1'b1;
            endcase
        end else begin
            case (opc)
                OpcAddi, OpcAddiu: begin
                    res  = x + sImm;
                    wide = longint'($signed(x)) + longint'($signed(sImm));
                    fl[FlagOvf] = (opc == OpcAddi) && (wide != longint'($signed(res)));
                end
                OpcSlti: begin
                    res         = x - sImm;
                    fl[FlagNeg] = $signed(x) < $signed(sImm);
                end
                OpcSltiu: begin
                    res         = x - sImm;
                    fl[FlagNeg] = x < sImm;
                end
                OpcOri:  res = x | zImm;
                OpcXori: res = x ^ zImm;
                OpcBeq: begin
                    fl[FlagZero] = (x == y);
                    res          = (x == y) ? (sImm << 2) : 32'd4;
                end
                OpcBne: begin
                    fl[FlagZero] = (x == y);
                    res          = (x == y) ? 32'd4 : (sImm << 2);
                end
                default: bad = 1'b1;
            endcase
        end
        if (bad) begin
            res = '0;
            fl  = '0;
        end
        expResult.push_back(res);
        expFlags.push_back(fl);
        expIllegal.push_back(bad);
    endtask

    // Input credits come back one per freed FIFO slot
    always @(posedge clk) begin
        if (rstN && inCredit) begin
            sendCredits++;
            inCreditCount++;
        end
    end

    always @(posedge clk) begin
        if (rstN && outValid) begin
            outCount++;
            owedCredits++;
            if (expResult.size() == 0) begin
                $display("outValid seen with no command outstanding");
                otherErrors++;
            end else begin
                checkResult(expResult.pop_front(), result);
                checkFlags(expFlags.pop_front(), flags);
                checkIllegal(expIllegal.pop_front(), illegal);
            end
        end
    end

    // Consumer returns one credit per cycle unless paused
    always @(negedge clk) begin
        if (!consumerPaused && owedCredits > 0) begin
            outCredit = 1'b1;
            owedCredits--;
        end else begin
            outCredit = 1'b0;
        end
    end

    initial begin
        #(CmdBudget * 40 * ClkPeriod);
        $display("timeout: the run did not finish within its time limit");
        $display("errors: %0d wrong values, %0d other failures", valueErrors, otherErrors);
        $display("test failed");
        $finish;
    end

    task automatic sendCmd(input instrWord ins, input logic [DataWidth-1:0] a,
                           input logic [DataWidth-1:0] b);
        @(negedge clk);
        while (sendCredits == 0) @(negedge clk);
        predict(ins, a, b);
        instr   = ins;
        regA    = a;
        regB    = b;
        inValid = 1'b1;
        sendCredits--;
        @(negedge clk);
        inValid = 1'b0;
    endtask

    task automatic waitDrain();
        while (expResult.size() != 0 || owedCredits != 0) @(negedge clk);
        @(negedge clk);
    endtask

    task automatic applyReset();
        rstN        = 1'b0;
        inValid     = 1'b0;
        sendCredits = FifoDepth;
        repeat (ResetCycles) begin
            @(negedge clk);
            checkLow("outValid", outValid);
            checkLow("inCredit", inCredit);
        end
        rstN = 1'b1;
    endtask

    task automatic testArith();
        logic [5:0]           funcs [4];
        logic [DataWidth-1:0] a;
        logic [DataWidth-1:0] b;
        int                   f;
        int                   rs;
        int                   rt;
        funcs = '{FnAdd, FnAddu, FnSub, FnSubu};
        for (f = 0; f < 4; f++) begin
            for (rs = 0; rs < 2; rs++) begin
                for (rt = 0; rt < 2; rt++) begin       // Includes same register twice
                    a = nextRand();
                    b = nextRand();
                    sendCmd(rInstr(funcs[f], 5'(rs), 5'(rt), 5'd0), a, b);
                end
            end
        end
        sendCmd(rInstr(FnAdd, 5'd0, 5'd1, 5'd0), 32'h7fff_ffff, 32'h0000_0001);
        sendCmd(rInstr(FnAdd, 5'd0, 5'd1, 5'd0), 32'h8000_0000, 32'h8000_0000);
        sendCmd(rInstr(FnAddu, 5'd0, 5'd1, 5'd0), 32'h7fff_ffff, 32'h0000_0001);
        sendCmd(rInstr(FnSub, 5'd0, 5'd1, 5'd0), 32'h8000_0000, 32'h0000_0001);
        sendCmd(rInstr(FnSub, 5'd0, 5'd1, 5'd0), 32'h7fff_ffff, 32'hffff_ffff);
        sendCmd(rInstr(FnSubu, 5'd1, 5'd0, 5'd0), 32'h0000_0001, 32'h8000_0000);
        sendCmd(iInstr(OpcAddi, 5'd0, 5'd0, 16'h0001), 32'h7fff_ffff, 32'h0);
        sendCmd(iInstr(OpcAddi, 5'd1, 5'd0, 16'h8000), 32'h0, 32'h8000_0000);
        sendCmd(iInstr(OpcAddiu, 5'd0, 5'd0, 16'h0001), 32'h7fff_ffff, 32'h0);
        for (f = 0; f < 4; f++) begin
            a = nextRand();
            b = nextRand();
            sendCmd(iInstr(f[0] ? OpcAddi : OpcAddiu, 5'(f[1]), 5'd0, a[31:16]), a, b);
        end
        waitDrain();
    endtask

    task automatic testLogicShift();
        logic [5:0]           logicFns [4];
        logic [5:0]           shiftFns [3];
        logic [5:0]           varFns   [3];
        logic [4:0]           amounts  [3];
        logic [DataWidth-1:0] a;
        logic [DataWidth-1:0] b;
        int                   i;
        int                   j;
        logicFns = '{FnAnd, FnOr, FnNor, FnXor};
        shiftFns = '{FnSll, FnSrl, FnSra};
        varFns   = '{FnSllv, FnSrlv, FnSrav};
        amounts  = '{5'd0, 5'd31, 5'd0};
        a = nextRand();
        amounts[2] = a[4:0];
        for (i = 0; i < 4; i++) begin
            a = nextRand();
            b = nextRand();
            sendCmd(rInstr(logicFns[i], 5'd0, 5'd1, 5'd0), a, b);
        end
        sendCmd(iInstr(OpcOri, 5'd1, 5'd0, 16'h8a5c), 32'h0, 32'h0f0f_0000);
        sendCmd(iInstr(OpcXori, 5'd0, 5'd0, 16'hf00f), 32'hffff_ffff, 32'h0);
        for (i = 0; i < 3; i++) begin
            for (j = 0; j < 3; j++) begin
                b = nextRand() | 32'h8000_0000;        // Negative value for sra
                a = nextRand();
                sendCmd(rInstr(shiftFns[i], 5'd0, 5'd1, amounts[j]), a, b);
                a[4:0] = amounts[j];
                sendCmd(rInstr(varFns[i], 5'd0, 5'd1, 5'd0), a, b);
            end
        end
        waitDrain();
    endtask

    task automatic testCompareBranch();
        logic [DataWidth-1:0] a;
        a = nextRand();
        // Signed and unsigned orderings disagree here
        sendCmd(rInstr(FnSlt, 5'd0, 5'd1, 5'd0), 32'hffff_ffff, 32'h0000_0001);
        sendCmd(rInstr(FnSltu, 5'd0, 5'd1, 5'd0), 32'hffff_ffff, 32'h0000_0001);
        sendCmd(rInstr(FnSlt, 5'd1, 5'd0, 5'd0), 32'hffff_ffff, 32'h0000_0001);
        sendCmd(rInstr(FnSltu, 5'd1, 5'd0, 5'd0), 32'hffff_ffff, 32'h0000_0001);
        sendCmd(rInstr(FnSlt, 5'd0, 5'd0, 5'd0), a, 32'h0);
        sendCmd(iInstr(OpcSlti, 5'd0, 5'd0, 16'hffff), 32'h1, 32'h0);
        sendCmd(iInstr(OpcSltiu, 5'd0, 5'd0, 16'hffff), 32'h1, 32'h0);
        sendCmd(iInstr(OpcSlti, 5'd1, 5'd0, 16'h0010), 32'h0, 32'h8000_0000);
        sendCmd(iInstr(OpcSltiu, 5'd1, 5'd0, 16'h0010), 32'h0, 32'h8000_0000);
        sendCmd(iInstr(OpcBeq, 5'd0, 5'd0, 16'h0040), a, 32'h0);
        sendCmd(iInstr(OpcBeq, 5'd0, 5'd1, 16'hfff0), 32'h1, 32'h2);
        sendCmd(iInstr(OpcBeq, 5'd0, 5'd1, 16'h8000), a, a);
        sendCmd(iInstr(OpcBne, 5'd1, 5'd1, 16'h0123), a, a);
        sendCmd(iInstr(OpcBne, 5'd0, 5'd1, 16'h8001), 32'h1, 32'h2);
        waitDrain();
    endtask

    task automatic testIllegal();
        logic [DataWidth-1:0] a;
        logic [DataWidth-1:0] b;
        a = nextRand();
        b = nextRand();
        sendCmd(rInstr(FnAdd, 5'd2, 5'd1, 5'd0), a, b);
        sendCmd(rInstr(FnSub, 5'd0, 5'd2, 5'd0), a, b);
        sendCmd(iInstr(OpcBeq, 5'd0, 5'd2, 16'h0004), a, a);
        sendCmd(rInstr(6'b111111, 5'd0, 5'd1, 5'd0), a, b);
        sendCmd(iInstr(6'b100011, 5'd0, 5'd1, 16'h1234), a, b);     // Load word is dropped
        sendCmd(iInstr(OpcAddi, 5'd0, 5'd7, 16'h0010), a, b);       // rt unused, still legal
        waitDrain();
    endtask

    task automatic testBackPressure();
        logic [DataWidth-1:0] a;
        logic [DataWidth-1:0] b;
        int                   sent;
        int                   outStart;
        int                   creditStart;
        sent           = 0;
        outStart       = outCount;
        creditStart    = inCreditCount;
        consumerPaused = 1'b1;
        while (sendCredits > 0) begin
            a = nextRand();
            b = nextRand();
            sendCmd(rInstr(FnAddu, 5'd0, 5'd1, 5'd0), a, b);
            sent++;
        end
        repeat (10) @(negedge clk);
        if (outCount - outStart != OutCredits) begin
            $display("back-pressure: %0d results while paused, only %0d allowed",
                     outCount - outStart, OutCredits);
            otherErrors++;
        end
        if (inCreditCount - creditStart != OutCredits) begin
            $display("back-pressure: %0d input credits returned while stalled, wanted %0d",
                     inCreditCount - creditStart, OutCredits);
            otherErrors++;
        end
        consumerPaused = 1'b0;
        waitDrain();
        if (outCount - outStart != sent || inCreditCount - creditStart != sent) begin
            $display("back-pressure: sent %0d, got %0d results and %0d input credits",
                     sent, outCount - outStart, inCreditCount - creditStart);
            otherErrors++;
        end
    endtask

    task automatic testLatency();
        int startCount;
        int waited;
        applyReset();
        startCount = outCount;
        waited     = 0;
        sendCmd(rInstr(FnAdd, 5'd0, 5'd1, 5'd0), 32'd5, 32'd7);
        while (outCount == startCount && waited < 10) begin
            @(negedge clk);
            waited++;
        end
        if (outCount == startCount) begin
            $display("latency: no outValid after a single command");
            otherErrors++;
        end
        waitDrain();
    endtask

    initial begin
        rstN      = 1'b0;
        inValid   = 1'b0;
        instr     = '0;
        regA      = '0;
        regB      = '0;
        outCredit = 1'b0;
        applyReset();
        testArith();
        testLogicShift();
        testCompareBranch();
        testIllegal();
        testBackPressure();
        testLatency();
        $display("errors: %0d wrong values, %0d other failures", valueErrors, otherErrors);
        if (valueErrors + otherErrors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
